/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_correlator_block
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# Build and run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/corr_pkg.sv */
`default_nettype none

package corr_pkg;

   // ------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------
   localparam int ACCUM_BITS  = 8;             // One count, wraps modulo 256
   localparam int NUM_ANTENNA = 4;             // Sign bits per component
   localparam int ANT_BITS    = $clog2(NUM_ANTENNA);

   localparam int TRATE = 4;                   // Pair slots per pass
   localparam int TBITS = $clog2(TRATE);       // Slot index width

   localparam int BLOCK_BITS = 2;              // Four buffer blocks

   // Bus address is {block, slot, word}
   localparam int ABITS = BLOCK_BITS + TBITS + 1;

   // ------------------------------------------------------------
   // Antenna pairs, one per slot
   // ------------------------------------------------------------
   // Index [slot][0] is the first antenna, [slot][1] the second
   localparam logic [ANT_BITS-1:0] PAIR_TABLE [TRATE][2] = '{
      '{2'd0, 2'd1},                           // Slot 0
      '{2'd0, 2'd2},                           // Slot 1
      '{2'd1, 2'd3},                           // Slot 2
      '{2'd2, 2'd3}                            // Slot 3
   };

   // ------------------------------------------------------------
   // Enums
   // ------------------------------------------------------------
   // Accumulator pass state
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,                         // Not enabled, waiting for a pass
      ST_CLEAR = 2'd1,                         // First pass into a block
      ST_ACCUM = 2'd2                          // Adding onto stored counts
   } acc_state_e;

   // Word inside one visibility
   typedef enum logic {
      WORD_COS = 1'b0,
      WORD_SIN = 1'b1
   } vis_word_e;

endpackage

`default_nettype wire

/* hdl/correlator_block.sv */
`timescale 1ns/1ps
`default_nettype none

module correlator_block import corr_pkg::*; (
   input  wire logic                   clk_x,
   input  wire logic                   rst,

   // Antenna side
   input  wire logic                   en_i,            // Samples valid
   input  wire logic                   sw_i,            // Bank switch pulse
   input  wire logic [NUM_ANTENNA-1:0] re_i,            // Real sign bits
   input  wire logic [NUM_ANTENNA-1:0] im_i,            // Imag sign bits

   // Wishbone-like read-back bus
   input  wire logic                   cyc_i,
   input  wire logic                   stb_i,
   input  wire logic                   we_i,
   input  wire logic [ABITS-1:0]       adr_i,
   output logic                        ack_o,
   output logic      [ACCUM_BITS-1:0]  dat_o,

   // Sticky wrap flags
   output logic                        overflow_cos_o,
   output logic                        overflow_sin_o
);

   // ------------------------------------------------------------
   // Internal links
   // ------------------------------------------------------------
   vis_wr_if vis_wr ();                         // Producer to buffer

   logic [BLOCK_BITS+TBITS-1:0] rd_adr;        // Reader to buffer
   logic [1:0][ACCUM_BITS-1:0]  rd_dat;        // Buffer to reader

   correlator_mac u_mac (
      .clk_x          (clk_x),
      .rst            (rst),
      .en_i           (en_i),
      .sw_i           (sw_i),
      .re_i           (re_i),
      .im_i           (im_i),
      .vis            (vis_wr.producer),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   visibility_buffer u_buf (
      .clk_x    (clk_x),
      .vis      (vis_wr.buffer),
      .rd_adr_i (rd_adr),
      .rd_dat_o (rd_dat)
   );

   vis_bus_reader u_reader (
      .clk_x    (clk_x),
      .rst      (rst),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .rd_adr_o (rd_adr),
      .rd_dat_i (rd_dat),
      .ack_o    (ack_o),
      .dat_o    (dat_o)
   );

endmodule

`default_nettype wire

/* hdl/correlator_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module correlator_mac import corr_pkg::*; (
   input  wire logic                   clk_x,
   input  wire logic                   rst,
   input  wire logic                   en_i,       // Samples valid
   input  wire logic                   sw_i,       // Bank switch pulse
   input  wire logic [NUM_ANTENNA-1:0] re_i,
   input  wire logic [NUM_ANTENNA-1:0] im_i,
   vis_wr_if.producer                  vis,
   output logic                        overflow_cos_o,
   output logic                        overflow_sin_o
);

   acc_state_e            state;
   logic                  swap_pend, swap_req;
   logic [TBITS-1:0]      rd_slot, wr_slot;
   logic                  rd_wrap, wr_wrap;
   logic [BLOCK_BITS-1:0] rd_blk, wr_blk;
   logic                  wr_vld;
   logic                  clr_now, clr_q;
   logic [ANT_BITS-1:0]   ant_a, ant_b;
   logic                  cos_bit, sin_bit;
   logic                  cos_bit_q, sin_bit_q;
   logic [ACCUM_BITS-1:0] acc_cos [TRATE];     // Per-slot accumulator store
   logic [ACCUM_BITS-1:0] acc_sin [TRATE];
   logic [ACCUM_BITS-1:0] old_cos_q, old_sin_q;
   logic [ACCUM_BITS:0]   sum_cos, sum_sin;    // Extra bit is the carry
   logic [ACCUM_BITS-1:0] cos_q, sin_q;
   logic                  cos_cry_q, sin_cry_q;

   rmw_address_unit u_rmw (
      .clk_x      (clk_x),
      .rst        (rst),
      .ce_i       (en_i),
      .swap_req_i (swap_req),
      .rd_slot_o  (rd_slot),
      .wr_slot_o  (wr_slot),
      .rd_wrap_o  (rd_wrap),
      .wr_wrap_o  (wr_wrap),
      .rd_blk_o   (rd_blk),
      .wr_blk_o   (wr_blk),
      .valid_o    (wr_vld)
   );

   // ------------------------------------------------------------
   // Pending swap and pass state
   // ------------------------------------------------------------
   assign swap_req = swap_pend | sw_i;         // Pulse may land on the wrap itself

   always_ff @(posedge clk_x) begin
      if (rst)
         swap_pend <= 1'b0;
      else if (en_i && rd_wrap)
         swap_pend <= 1'b0;                    // Taken by the block tag
      else
         swap_pend <= swap_req;
   end

   // Slot 0 read straight out of idle opens the clear pass
   assign clr_now = (state == ST_CLEAR) || (state == ST_IDLE && rd_slot == '0);

   always_ff @(posedge clk_x) begin
      if (rst || !en_i)
         state <= ST_IDLE;
      else if (rd_wrap)
         state <= (swap_req || state == ST_IDLE) ? ST_CLEAR : ST_ACCUM;
      else if (state == ST_IDLE && rd_slot == '0)
         state <= ST_CLEAR;
   end

   // ------------------------------------------------------------
   // Read stage: pair select and 1-bit multiply
   // ------------------------------------------------------------
   assign ant_a   = PAIR_TABLE[rd_slot][0];
   assign ant_b   = PAIR_TABLE[rd_slot][1];
   assign cos_bit = ~(re_i[ant_a] ^ re_i[ant_b]);   // Re/Re agree
   assign sin_bit = ~(im_i[ant_a] ^ re_i[ant_b]);   // Im/Re agree

   always_ff @(posedge clk_x) begin
      cos_bit_q <= cos_bit;
      sin_bit_q <= sin_bit;
      clr_q     <= clr_now;
      old_cos_q <= acc_cos[rd_slot];
      old_sin_q <= acc_sin[rd_slot];
   end

   // Accumulate stage, zero base in a clear pass
   assign sum_cos = (clr_q ? '0 : {1'b0, old_cos_q}) + (ACCUM_BITS+1)'(cos_bit_q);
   assign sum_sin = (clr_q ? '0 : {1'b0, old_sin_q}) + (ACCUM_BITS+1)'(sin_bit_q);

   always_ff @(posedge clk_x) begin
      cos_q     <= sum_cos[ACCUM_BITS-1:0];
      sin_q     <= sum_sin[ACCUM_BITS-1:0];
      cos_cry_q <= sum_cos[ACCUM_BITS];
      sin_cry_q <= sum_sin[ACCUM_BITS];
      if (wr_vld) begin                        // Write-back, same cycle as the strobe
         acc_cos[wr_slot] <= cos_q;
         acc_sin[wr_slot] <= sin_q;
      end
   end

   // Sticky wrap flags
   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else if (wr_vld) begin
         if (cos_cry_q)
            overflow_cos_o <= 1'b1;
         if (sin_cry_q)
            overflow_sin_o <= 1'b1;
      end
   end

   assign vis.we   = wr_vld;
   assign vis.blk  = wr_blk;
   assign vis.slot = wr_slot;
   assign vis.cos  = cos_q;
   assign vis.sin  = sin_q;

   // No write strobe while reset is held
   a_no_wr_in_rst : assert property (@(posedge clk_x)
      rst |-> (vis.we !== 1'b1));

   // Block tag on the write side only moves after a pass-end write
   a_wr_blk_hold : assert property (@(posedge clk_x) disable iff (rst)
      (wr_vld && !wr_wrap) |=> $stable(wr_blk));

endmodule

`default_nettype wire

/* hdl/rmw_address_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rmw_address_unit import corr_pkg::*; (
   input  wire logic                  clk_x,
   input  wire logic                  rst,
   input  wire logic                  ce_i,        // Read cycle
   input  wire logic                  swap_req_i,  // Switch block at this wrap
   output logic      [TBITS-1:0]      rd_slot_o,
   output logic      [TBITS-1:0]      wr_slot_o,
   output logic                       rd_wrap_o,
   output logic                       wr_wrap_o,
   output logic      [BLOCK_BITS-1:0] rd_blk_o,
   output logic      [BLOCK_BITS-1:0] wr_blk_o,
   output logic                       valid_o      // Write-stage strobe
);

   // Accumulate stage
   logic                  vld1;
   logic [TBITS-1:0]      slot1;
   logic [BLOCK_BITS-1:0] blk1;

   assign rd_wrap_o = (rd_slot_o == TBITS'(TRATE - 1));
   assign wr_wrap_o = (wr_slot_o == TBITS'(TRATE - 1));

   // ------------------------------------------------------------
   // Read pointer and block tag
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         rd_slot_o <= '0;
         rd_blk_o  <= '0;
      end else if (ce_i) begin
         rd_slot_o <= rd_wrap_o ? '0 : rd_slot_o + 1'b1;
         if (rd_wrap_o && swap_req_i)
            rd_blk_o <= rd_blk_o + 1'b1;       // Next pass goes to a fresh block
      end
   end

   // Two-stage delay, tag travels with its slot
   always_ff @(posedge clk_x) begin
      if (rst) begin
         vld1      <= 1'b0;
         valid_o   <= 1'b0;
         slot1     <= '0;
         blk1      <= '0;
         wr_slot_o <= '0;
         wr_blk_o  <= '0;
      end else begin
         vld1    <= ce_i;
         valid_o <= vld1;
         if (ce_i) begin                       // Hold across idle cycles
            slot1 <= rd_slot_o;
            blk1  <= rd_blk_o;
         end
         if (vld1) begin
            wr_slot_o <= slot1;
            wr_blk_o  <= blk1;
         end
      end
   end

   // Write side lags the read side by exactly two enabled cycles
   a_wr_slot_lag : assert property (@(posedge clk_x) disable iff (rst)
      valid_o |-> (wr_slot_o == $past(rd_slot_o, 2)));

endmodule

`default_nettype wire

/* hdl/vis_bus_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module vis_bus_reader import corr_pkg::*; (
   input  wire logic                          clk_x,
   input  wire logic                          rst,
   input  wire logic                          cyc_i,
   input  wire logic                          stb_i,
   input  wire logic                          we_i,      // Writes acked like reads
   input  wire logic [ABITS-1:0]              adr_i,     // {block, slot, word}
   output logic      [BLOCK_BITS+TBITS-1:0]   rd_adr_o,
   input  wire logic [1:0][ACCUM_BITS-1:0]    rd_dat_i,
   output logic                               ack_o,
   output logic      [ACCUM_BITS-1:0]         dat_o
);

   logic      req;                              // Bus request this cycle
   logic      ack_q;                            // First acknowledge stage
   vis_word_e word_q;                           // Word of the request in flight

   assign req = cyc_i & stb_i;

   // Block and slot go straight to the buffer read port
   assign rd_adr_o = adr_i[ABITS-1:1];

   // ------------------------------------------------------------
   // Data path, buffer answers one cycle after the request
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (req)
         word_q <= vis_word_e'(adr_i[0]);
      dat_o <= rd_dat_i[word_q];                // Valid together with ack_o
   end

   // Two-stage acknowledge, dropped if the cycle ends early
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_q <= 1'b0;
         ack_o <= 1'b0;
      end else begin
         ack_q <= req;
         ack_o <= ack_q & cyc_i;
      end
   end

   // Every acknowledge traces back to a request
   a_ack_has_req : assert property (@(posedge clk_x) disable iff (rst)
      ack_o |-> $past(req, 2));

endmodule

`default_nettype wire

/* hdl/vis_wr_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Accumulated visibilities, one slot per write strobe
interface vis_wr_if import corr_pkg::*; ();

   logic                  we;                  // One-cycle write strobe
   logic [BLOCK_BITS-1:0] blk;                 // Target block
   logic [TBITS-1:0]      slot;                // Pair slot
   logic [ACCUM_BITS-1:0] cos;                 // Real agreement count
   logic [ACCUM_BITS-1:0] sin;                 // Imag/real agreement count

   // No back-pressure, buffer takes every write
   modport producer (
      output we, blk, slot, cos, sin
   );

   modport buffer (
      input  we, blk, slot, cos, sin
   );

endinterface

`default_nettype wire

/* hdl/visibility_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module visibility_buffer import corr_pkg::*; (
   input  wire logic                          clk_x,
   vis_wr_if.buffer                           vis,
   input  wire logic [BLOCK_BITS+TBITS-1:0]   rd_adr_i,  // {block, slot}
   output logic      [1:0][ACCUM_BITS-1:0]    rd_dat_o   // Indexed by vis_word_e
);

   // ------------------------------------------------------------
   // Storage, one entry per block and slot
   // ------------------------------------------------------------
   // Word 0 holds cos, word 1 holds sin
   logic [1:0][ACCUM_BITS-1:0] mem [1 << (BLOCK_BITS + TBITS)];

   // Write port, every strobe lands
   always_ff @(posedge clk_x) begin
      if (vis.we)
         mem[{vis.blk, vis.slot}] <= {vis.sin, vis.cos};
   end

   // Read port, one registered cycle
   // Same-cycle write to the same entry returns the old value
   always_ff @(posedge clk_x) begin
      rd_dat_o <= mem[rd_adr_i];
   end

   // Producer must never strobe with an undriven tag
   a_wr_adr_known : assert property (@(posedge clk_x)
      vis.we |-> !$isunknown({vis.blk, vis.slot}));

endmodule

`default_nettype wire

/* verification/tb_correlator_block.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_correlator_block import corr_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int PASSES_A   = 6;              // Into block 0
   localparam int PASSES_B   = 5;              // Into block 1
   localparam int PASSES_OVF = 260;            // Past one wrap of a count
   // Feed cycles, three 8-word readbacks, protocol test, margin
   localparam int WATCHDOG_NS = CLK_PERIOD *
      (8 + TRATE * (PASSES_A + PASSES_B + PASSES_OVF) + 3 * 8 * 8 + 60 + 400);

   logic                   clk_x = 1'b0;
   logic                   rst, en_i, sw_i, cyc_i, stb_i, we_i;
   logic [NUM_ANTENNA-1:0] re_i, im_i;
   logic [ABITS-1:0]       adr_i;
   logic                   ack_o, overflow_cos_o, overflow_sin_o;
   logic [ACCUM_BITS-1:0]  dat_o;

   integer seed = 32'h7363_f5a0;

   // Reference model state
   int exp_acc [TRATE][2];                     // Per-slot counts, [slot][word]
   int exp_mem [1 << BLOCK_BITS][TRATE][2];    // Buffer image
   int m_blk;                                  // Block being filled
   bit m_clear, m_ovf_cos, m_ovf_sin;

   correlator_block UUT (.*);

   always #(CLK_PERIOD / 2) clk_x = ~clk_x;

   // ------------------------------------------------------------
   // Reporting
   // ------------------------------------------------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp)
         stop_with_failure($sformatf("[ERROR] t=%0t %s expected %0d, got %0d",
                                     $time, name, exp, act));
   endtask

   // ------------------------------------------------------------
   // Model and stimulus
   // ------------------------------------------------------------
   // Agreement of x at the first antenna with y at the second
   function automatic bit agree(input logic [NUM_ANTENNA-1:0] x, y, input int s);
      return x[PAIR_TABLE[s][0]] == y[PAIR_TABLE[s][1]];
   endfunction

   task automatic model_step(input int s, input logic [NUM_ANTENNA-1:0] re, im);
      int sum_cos, sum_sin;
      sum_cos = (m_clear ? 0 : exp_acc[s][0]) + int'(agree(re, re, s));
      sum_sin = (m_clear ? 0 : exp_acc[s][1]) + int'(agree(im, re, s));
      if (sum_cos >= (1 << ACCUM_BITS))
         m_ovf_cos = 1'b1;                     // Sticky like the DUT flag
      if (sum_sin >= (1 << ACCUM_BITS))
         m_ovf_sin = 1'b1;
      exp_acc[s][0] = sum_cos % (1 << ACCUM_BITS);
      exp_acc[s][1] = sum_sin % (1 << ACCUM_BITS);
      exp_mem[m_blk][s][0] = exp_acc[s][0];
      exp_mem[m_blk][s][1] = exp_acc[s][1];
   endtask

   // Whole passes with enable held, optional swap pulse in the last one
   task automatic feed_passes(input int n, input bit all_ones, input bit swap_last);
      logic [31:0] r;
      for (int p = 0; p < n; p++) begin
         for (int s = 0; s < TRATE; s++) begin
            if (all_ones)
               r = '1;
            else
               r = $random(seed);
            @(posedge clk_x);
            en_i <= 1'b1;
            sw_i <= swap_last && p == n - 1 && s == 0;   // Held pending until the wrap
            re_i <= r[NUM_ANTENNA-1:0];
            im_i <= r[2*NUM_ANTENNA-1:NUM_ANTENNA];
            model_step(s, r[NUM_ANTENNA-1:0], r[2*NUM_ANTENNA-1:NUM_ANTENNA]);
         end
         m_clear = swap_last && p == n - 1;    // Swap opens a clear pass
         if (m_clear)
            m_blk = (m_blk + 1) % (1 << BLOCK_BITS);
      end
   endtask

   task automatic stop_feed();
      @(posedge clk_x);
      en_i <= 1'b0;
      m_clear = 1'b1;                          // Idle, next pass starts from zero
      repeat (3) @(posedge clk_x);             // Last write lands two cycles after its read
   endtask

   // Single bus read, waits for the acknowledge and checks its latency
   task automatic read_word(input int blk, slot, word, input bit we,
                            output logic [ACCUM_BITS-1:0] data);
      int lat;
      @(posedge clk_x);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= we;
      adr_i <= {BLOCK_BITS'(blk), TBITS'(slot), 1'(word)};
      @(posedge clk_x);
      stb_i <= 1'b0;                           // cyc_i stays up for the ack
      lat = 1;
      @(negedge clk_x);
      while (!ack_o) begin
         if (lat > 8)
            stop_with_failure("Bus read got no acknowledge within 8 cycles");
         lat++;
         @(negedge clk_x);
      end
      check_value("ack_o latency", 2, lat);
      data = dat_o;
      @(posedge clk_x);
      cyc_i <= 1'b0;
      we_i  <= 1'b0;
   endtask

   task automatic check_block(input int blk);
      logic [ACCUM_BITS-1:0] d;
      for (int s = 0; s < TRATE; s++) begin
         for (int w = 0; w < 2; w++) begin
            read_word(blk, s, w, 1'b0, d);
            check_value($sformatf("dat_o blk%0d slot%0d %s", blk, s,
                                  w == int'(WORD_COS) ? "cos" : "sin"),
                        exp_mem[blk][s][w], 32'(d));
         end
      end
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   task automatic test_reset_state();
      @(negedge clk_x);
      check_value("ack_o", 0, 32'(ack_o));
      check_value("overflow_cos_o", 0, 32'(overflow_cos_o));
      check_value("overflow_sin_o", 0, 32'(overflow_sin_o));
   endtask

   // Block 0 is read back while block 1 fills
   task automatic test_first_block();
      feed_passes(PASSES_A, 1'b0, 1'b1);
      fork
         begin
            feed_passes(PASSES_B, 1'b0, 1'b1);
            stop_feed();
         end
         begin
            repeat (TRATE) @(posedge clk_x);   // One more pass first
            check_block(0);
         end
      join
   endtask

   // Block 1 holds only passes after the switch
   task automatic test_clear_after_switch();
      check_block(1);
      check_value("overflow_cos_o", 32'(m_ovf_cos), 32'(overflow_cos_o));
      check_value("overflow_sin_o", 32'(m_ovf_sin), 32'(overflow_sin_o));
   endtask

   task automatic test_bus_protocol();
      logic [ACCUM_BITS-1:0] d;
      // Three back-to-back requests, ack exactly two cycles behind each
      for (int i = 0; i < 6; i++) begin
         @(posedge clk_x);
         cyc_i <= 1'b1;
         stb_i <= (i < 3);
         adr_i <= {BLOCK_BITS'(0), TBITS'(i), 1'(i)};
         @(negedge clk_x);
         check_value("ack_o back-to-back", 32'(i >= 2 && i < 5), 32'(ack_o));
         if (i >= 2 && i < 5)
            check_value("dat_o back-to-back", exp_mem[0][i-2][(i-2) % 2], 32'(dat_o));
      end
      // Strobe alone is no request, even with cyc_i up right after it
      @(posedge clk_x);
      cyc_i <= 1'b0;
      stb_i <= 1'b1;
      @(posedge clk_x);
      cyc_i <= 1'b1;                           // Second ack stage open
      stb_i <= 1'b0;
      repeat (4) begin
         @(negedge clk_x);
         check_value("ack_o without cyc_i", 0, 32'(ack_o));
      end
      // Write request answers like a read, storage untouched
      read_word(0, 3, WORD_SIN, 1'b1, d);
      check_value("dat_o on write request", exp_mem[0][3][1], 32'(d));
      read_word(0, 3, WORD_SIN, 1'b0, d);
      check_value("dat_o after write request", exp_mem[0][3][1], 32'(d));
   endtask

   task automatic test_overflow();
      check_value("overflow_cos_o before wrap", 0, 32'(overflow_cos_o));
      feed_passes(PASSES_OVF, 1'b1, 1'b1);     // Every pair agrees
      stop_feed();
      check_block(2);
      check_value("overflow_cos_o", 1, 32'(overflow_cos_o));
      check_value("overflow_sin_o", 1, 32'(overflow_sin_o));
      repeat (20) @(posedge clk_x);
      @(negedge clk_x);
      check_value("overflow_cos_o held", 1, 32'(overflow_cos_o));
      check_value("overflow_sin_o held", 1, 32'(overflow_sin_o));
   endtask

   initial begin
      #(WATCHDOG_NS);
      stop_with_failure("Watchdog expired before the tests finished");
   end

   initial begin
      rst       = 1'b1;
      en_i      = 1'b0;
      sw_i      = 1'b0;
      re_i      = '0;
      im_i      = '0;
      cyc_i     = 1'b0;
      stb_i     = 1'b0;
      we_i      = 1'b0;
      adr_i     = '0;
      m_blk     = 0;
      m_clear   = 1'b1;                        // First pass after reset clears
      m_ovf_cos = 1'b0;
      m_ovf_sin = 1'b0;
      repeat (8) @(posedge clk_x);
      rst <= 1'b0;
      test_reset_state();
      test_first_block();
      test_clear_after_switch();
      test_bus_protocol();
      test_overflow();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
hdl/corr_pkg.sv
hdl/vis_wr_if.sv
hdl/rmw_address_unit.sv
hdl/correlator_mac.sv
hdl/visibility_buffer.sv
hdl/vis_bus_reader.sv
hdl/correlator_block.sv
verification/tb_correlator_block.sv
